// File: all.f
dma_pkg.sv
dma_channel_regs.sv
dma_arbiter.sv
dma_burst_buffer.sv
dma_engine.sv
dma_top.sv
tb_dma_mem.sv
tb_dma.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_dma -f all.f

output=$(./obj_dir/Vtb_dma 2>&1 || true)
echo "$output"

if grep -qx "Simulation completed successfully" <<< "$output"; then
  exit 0
else
  exit 1
fi

// File: tb_dma.sv
`default_nettype none
`timescale 1ns/1ps

module tb_dma import dma_pkg::*; ();

  localparam int NCH      = 3;
  // Generous bound over the total length of all tests
  localparam int WATCHDOG = 20000;
  localparam int WAIT_MAX = 4000;

  logic           clk = 1'b0;
  logic           rst_n;
  logic           psel;
  logic           penable;
  logic           pwrite;
  logic [5:0]     paddr;
  word_t          pwdata;
  word_t          prdata;
  logic           pready;
  logic           pslverr;
  logic           mem_req;
  logic           mem_write;
  addr_t          mem_addr;
  word_t          mem_wdata;
  logic           mem_ready;
  word_t          mem_rdata;
  logic [NCH-1:0] done_intr;
  logic           slow;

  word_t          src_words [64];
  word_t          exp_data [NCH][64];
  int             exp_base [NCH];
  int             exp_len [NCH];
  word_t          cfg_ctrl [NCH];
  int             start_mark [NCH];
  int             done_count [NCH];
  int             finish_rank [NCH];
  int             rank_ctr;
  logic [NCH-1:0] done_prev;

  dma_top #(
    .NUM_CH (NCH)
  ) i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .mem_req   (mem_req),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .done_intr (done_intr)
  );

  tb_dma_mem i_mem (
    .clk   (clk),
    .rst_n (rst_n),
    .slow  (slow),
    .req   (mem_req),
    .write (mem_write),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .ready (mem_ready),
    .rdata (mem_rdata)
  );

  always #10 clk = ~clk;

  // ================================================
  // Helpers
  // ================================================
  task automatic check_value(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string why);
    $display("ERROR at %0t: %s", $time, why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  function automatic word_t fill_word(input logic [9:0] idx);
    return {~idx, 12'h3c5, idx};
  endfunction

  function automatic word_t ctrl_word(input logic start, input logic [1:0] mode,
                                      input logic sfix, input logic dfix,
                                      input logic [2:0] prio);
    word_t w;
    w = '0;
    w[CTRL_START]                = start;
    w[CTRL_MODE_HI:CTRL_MODE_LO] = mode;
    w[CTRL_SRC_FIXED]            = sfix;
    w[CTRL_DST_FIXED]            = dfix;
    w[CTRL_PRIO_HI:CTRL_PRIO_LO] = prio;
    return w;
  endfunction

  // Expected destination image of one transfer and its length in words
  function automatic int model_transfer(input int ch, input int n,
                                        input logic sfix, input logic dfix);
    word_t v;
    for (int i = 0; i < n; i++)
    begin
      v = sfix ? src_words[0] : src_words[i];
      if (dfix)
        exp_data[ch][0] = v;
      else
        exp_data[ch][i] = v;
    end
    return dfix ? 1 : n;
  endfunction

  // One setup cycle and one access cycle
  task automatic apb_transfer(input logic wr, input logic [5:0] addr, input word_t wdata,
                              output word_t rdata, output logic slverr);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(posedge clk);
    rdata  = prdata;
    slverr = pslverr;
    check_value("pready", word_t'(pready), 32'd1);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic write_reg(input int ch, input logic [3:0] off, input word_t data);
    word_t rdata;
    logic  slverr;
    apb_transfer(1'b1, {2'(ch), off}, data, rdata, slverr);
    check_value("pslverr", word_t'(slverr), '0);
  endtask

  task automatic read_reg(input int ch, input logic [3:0] off, output word_t data);
    logic slverr;
    apb_transfer(1'b0, {2'(ch), off}, '0, data, slverr);
    check_value("pslverr", word_t'(slverr), '0);
  endtask

  task automatic program_channel(input int ch, input int src, input int dst, input int n,
                                 input logic [1:0] mode, input logic sfix,
                                 input logic dfix, input logic [2:0] prio);
    for (int i = 0; i < n; i++)
      src_words[i] = fill_word(10'(src + i));
    exp_base[ch] = dst;
    exp_len[ch]  = model_transfer(ch, n, sfix, dfix);
    cfg_ctrl[ch] = ctrl_word(1'b1, mode, sfix, dfix, prio);
    write_reg(ch, REG_SRC, word_t'(src * 4));
    write_reg(ch, REG_DST, word_t'(dst * 4));
    write_reg(ch, REG_COUNT, word_t'(n));
  endtask

  task automatic start_channel(input int ch);
    start_mark[ch] = done_count[ch];
    write_reg(ch, REG_CTRL, cfg_ctrl[ch]);
  endtask

  task automatic clear_done(input int ch);
    write_reg(ch, REG_CTRL, word_t'(1) << CTRL_DONE);
  endtask

  task automatic wait_done(input int ch);
    int n;
    n = 0;
    while (done_count[ch] == start_mark[ch])
    begin
      @(posedge clk);
      #1;
      n++;
      if (n > WAIT_MAX)
        abort_run($sformatf("channel %0d never raised its done interrupt", ch));
    end
  endtask

  // ================================================
  // Destination check on each rising done_intr
  // ================================================
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      rank_ctr = 0;
      for (int c = 0; c < NCH; c++)
        done_count[c] = 0;
    end
    else
    begin
      for (int c = 0; c < NCH; c++)
      begin
        if (done_intr[c] && !done_prev[c])
        begin
          for (int i = 0; i < exp_len[c]; i++)
            check_value($sformatf("ch%0d dst word %0d", c, i),
                        i_mem.mem[10'(exp_base[c] + i)], exp_data[c][i]);
          finish_rank[c] = rank_ctr;
          rank_ctr       = rank_ctr + 1;
          done_count[c]  = done_count[c] + 1;
        end
      end
    end
    done_prev = done_intr;
  end

  initial
  begin
    repeat (WATCHDOG) @(posedge clk);
    abort_run("watchdog expired, the run did not finish in time");
  end

  initial
  begin
    word_t v;
    logic  err;
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    slow    = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Outputs idle out of reset
    check_value("mem_req after reset", word_t'(mem_req), '0);
    check_value("pslverr after reset", word_t'(pslverr), '0);
    check_value("done_intr after reset", word_t'(done_intr), '0);

    // Register readback
    for (int c = 0; c < NCH; c++)
    begin
      write_reg(c, REG_SRC, 32'h1000_0000 + word_t'(c * 16));
      write_reg(c, REG_DST, 32'h2000_0004 + word_t'(c * 16));
      write_reg(c, REG_COUNT, 32'h0000_0123 + word_t'(c));
    end
    for (int c = 0; c < NCH; c++)
    begin
      read_reg(c, REG_SRC, v);
      check_value("SRC readback", v, 32'h1000_0000 + word_t'(c * 16));
      read_reg(c, REG_DST, v);
      check_value("DST readback", v, 32'h2000_0004 + word_t'(c * 16));
      read_reg(c, REG_COUNT, v);
      check_value("COUNT readback", v, 32'h0000_0123 + word_t'(c));
    end

    // Incrementing quad copy with a short tail chunk
    program_channel(0, 0, 100, 11, BM_QUAD, 1'b0, 1'b0, 3'd1);
    start_channel(0);
    wait_done(0);
    check_value("done_intr[0]", word_t'(done_intr[0]), 32'd1);
    read_reg(0, REG_COUNT, v);
    check_value("ch0 COUNT", v, '0);
    read_reg(0, REG_CTRL, v);
    check_value("ch0 CTRL done", word_t'(v[CTRL_DONE]), 32'd1);
    clear_done(0);
    read_reg(0, REG_CTRL, v);
    check_value("ch0 CTRL done", word_t'(v[CTRL_DONE]), '0);
    check_value("done_intr[0]", word_t'(done_intr[0]), '0);

    // Fixed source fill followed by a fixed destination copy
    program_channel(1, 200, 300, 5, BM_SINGLE, 1'b1, 1'b0, 3'd2);
    start_channel(1);
    wait_done(1);
    clear_done(1);
    program_channel(1, 400, 500, 6, BM_DUAL, 1'b0, 1'b1, 3'd2);
    start_channel(1);
    wait_done(1);
    clear_done(1);

    // ================================================
    // Priority and tie break
    // ================================================
    program_channel(0, 600, 650, 8, BM_QUAD, 1'b0, 1'b0, 3'd1);
    program_channel(2, 700, 750, 8, BM_QUAD, 1'b0, 1'b0, 3'd5);
    start_channel(0);
    start_channel(2);
    wait_done(0);
    wait_done(2);
    check_value("ch2 before ch0", word_t'(finish_rank[2] < finish_rank[0]), 32'd1);
    clear_done(0);
    clear_done(2);

    // Channel 2 takes the first chunk and ties then go to channel 0
    program_channel(0, 800, 850, 8, BM_QUAD, 1'b0, 1'b0, 3'd3);
    program_channel(2, 900, 950, 8, BM_QUAD, 1'b0, 1'b0, 3'd3);
    start_channel(2);
    start_channel(0);
    wait_done(0);
    wait_done(2);
    check_value("ch0 before ch2", word_t'(finish_rank[0] < finish_rank[2]), 32'd1);
    clear_done(0);
    clear_done(2);

    // Back-pressure from long ready stalls
    slow = 1'b1;
    program_channel(1, 20, 40, 9, BM_QUAD, 1'b0, 1'b0, 3'd4);
    start_channel(1);
    wait_done(1);
    slow = 1'b0;
    clear_done(1);

    // Unmapped channel 3
    apb_transfer(1'b1, {2'd3, REG_SRC}, 32'hdead_beef, v, err);
    check_value("ch3 write pslverr", word_t'(err), 32'd1);
    apb_transfer(1'b0, {2'd3, REG_SRC}, '0, v, err);
    check_value("ch3 read pslverr", word_t'(err), 32'd1);
    check_value("ch3 prdata", v, '0);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_dma_mem.sv
`default_nettype none
`timescale 1ns/1ps

module tb_dma_mem import dma_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  slow,
  input  logic  req,
  input  logic  write,
  input  addr_t addr,
  input  word_t wdata,
  output logic  ready,
  output word_t rdata
);

  word_t       mem [1024];
  logic [31:0] lcg;
  logic [3:0]  stall;
  logic        ready_q = 1'b0;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  assign ready = ready_q;
  assign rdata = mem[addr[11:2]];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      lcg     <= 32'd28;
      stall   <= '0;
      ready_q <= 1'b0;
    end
    else
    begin
      lcg <= lcg_next(lcg);
      // About three ready cycles in four
      if (!slow)
        ready_q <= (lcg[17:16] != 2'b00);
      else if (stall != '0)
      begin
        ready_q <= 1'b0;
        stall   <= stall - 4'd1;
      end
      else
      begin
        // One ready cycle, then a low run of 4 to 11
        ready_q <= 1'b1;
        stall   <= 4'd4 + {1'b0, lcg[18:16]};
      end
    end
  end

  // Fill pattern covers every address bit
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 1024; i++)
        mem[i] <= {~10'(i), 12'h3c5, 10'(i)};
    end
    else if (req && ready && write)
      mem[addr[11:2]] <= wdata;
  end

endmodule

`default_nettype wire

// File: dma_top.sv
`default_nettype none
`timescale 1ns/1ps

module dma_top import dma_pkg::*; #(
  parameter int NUM_CH = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [5:0]        paddr,
  input  word_t             pwdata,
  output word_t             prdata,
  output logic              pready,
  output logic              pslverr,
  output logic              mem_req,
  output logic              mem_write,
  output addr_t             mem_addr,
  output word_t             mem_wdata,
  input  logic              mem_ready,
  input  word_t             mem_rdata,
  output logic [NUM_CH-1:0] done_intr
);

  logic [1:0]         sel_ch;
  logic               ch_valid;
  logic               apb_access;
  logic [NUM_CH-1:0]  wr_en;
  logic [NUM_CH-1:0]  rd_en;
  word_t              rdata_list [NUM_CH];
  addr_t              src_list [NUM_CH];
  addr_t              dst_list [NUM_CH];
  count_t             count_list [NUM_CH];
  burst_mode_t        mode_list [NUM_CH];
  logic [NUM_CH-1:0]  src_fixed_list;
  logic [NUM_CH-1:0]  dst_fixed_list;
  prio_t [NUM_CH-1:0] prio_list;
  logic [NUM_CH-1:0]  pending;
  logic [NUM_CH-1:0]  grant_oh;
  logic [1:0]         owner;
  logic               go;
  logic               arbitrate;
  logic               busy;
  logic               fresh;
  logic               chunk_start;
  logic               chunk_done;
  addr_t              src_next;
  addr_t              dst_next;
  count_t             count_next;
  logic               buf_push;
  logic               buf_pop;
  word_t              buf_data_in;
  word_t              buf_data_out;
  logic               buf_empty;

  // ================================================
  // APB decode
  // ================================================
  assign sel_ch     = paddr[5:4];
  assign ch_valid   = int'(sel_ch) < NUM_CH;
  assign apb_access = psel && penable;
  assign pready     = 1'b1;
  assign pslverr    = apb_access && !ch_valid;

  // Only the selected bank drives nonzero read data
  always_comb
  begin
    prdata = '0;
    for (int i = 0; i < NUM_CH; i++)
      prdata = prdata | rdata_list[i];
  end

  for (genvar i = 0; i < NUM_CH; i++)
  begin : g_ch
    assign wr_en[i] = apb_access && pwrite && (sel_ch == 2'(i));
    assign rd_en[i] = psel && !pwrite && (sel_ch == 2'(i));

    dma_channel_regs u_regs (
      .clk        (clk),
      .rst_n      (rst_n),
      .wr_en      (wr_en[i]),
      .rd_en      (rd_en[i]),
      .reg_offset (paddr[3:0]),
      .wdata      (pwdata),
      .rdata      (rdata_list[i]),
      .granted    (grant_oh[i]),
      .chunk_done (chunk_done),
      .src_next   (src_next),
      .dst_next   (dst_next),
      .count_next (count_next),
      .src_addr   (src_list[i]),
      .dst_addr   (dst_list[i]),
      .count      (count_list[i]),
      .burst_mode (mode_list[i]),
      .src_fixed  (src_fixed_list[i]),
      .dst_fixed  (dst_fixed_list[i]),
      .prio       (prio_list[i]),
      .pending    (pending[i]),
      .done_intr  (done_intr[i])
    );
  end

  // ================================================
  // Chunk-boundary arbitration
  // ================================================
  // One arbitration cycle in IDLE before every chunk
  assign go        = fresh && |(pending & grant_oh);
  assign arbitrate = !busy && !go;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      busy  <= 1'b0;
      fresh <= 1'b0;
    end
    else
    begin
      if (chunk_start)
        busy <= 1'b1;
      else if (chunk_done)
        busy <= 1'b0;
      if (arbitrate)
        fresh <= 1'b1;
      else if (chunk_start)
        fresh <= 1'b0;
    end
  end

  dma_arbiter #(
    .NUM_CH (NUM_CH)
  ) u_arbiter (
    .clk       (clk),
    .rst_n     (rst_n),
    .pending   (pending),
    .prio_list (prio_list),
    .arbitrate (arbitrate),
    .grant_oh  (grant_oh),
    .owner     (owner)
  );

  dma_engine u_engine (
    .clk          (clk),
    .rst_n        (rst_n),
    .go           (go),
    .src_addr     (src_list[owner]),
    .dst_addr     (dst_list[owner]),
    .count        (count_list[owner]),
    .burst_mode   (mode_list[owner]),
    .src_fixed    (src_fixed_list[owner]),
    .dst_fixed    (dst_fixed_list[owner]),
    .chunk_start  (chunk_start),
    .chunk_done   (chunk_done),
    .src_next     (src_next),
    .dst_next     (dst_next),
    .count_next   (count_next),
    .mem_req      (mem_req),
    .mem_write    (mem_write),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_ready    (mem_ready),
    .mem_rdata    (mem_rdata),
    .buf_push     (buf_push),
    .buf_pop      (buf_pop),
    .buf_data_in  (buf_data_in),
    .buf_data_out (buf_data_out)
  );

  dma_burst_buffer u_buffer (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (chunk_start),
    .push      (buf_push),
    .pop       (buf_pop),
    .push_data (buf_data_in),
    .pop_data  (buf_data_out),
    .empty     (buf_empty),
    .full      ()
  );

  // Every chunk writes out exactly what it read
  a_chunk_drains_buffer: assert property (
    @(posedge clk) disable iff (!rst_n) chunk_done |=> buf_empty
  ) else $error("burst buffer not empty after chunk");

endmodule

`default_nettype wire

// File: dma_engine.sv
`default_nettype none
`timescale 1ns/1ps

module dma_engine import dma_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        go,
  input  addr_t       src_addr,
  input  addr_t       dst_addr,
  input  count_t      count,
  input  burst_mode_t burst_mode,
  input  logic        src_fixed,
  input  logic        dst_fixed,
  output logic        chunk_start,
  output logic        chunk_done,
  output addr_t       src_next,
  output addr_t       dst_next,
  output count_t      count_next,
  output logic        mem_req,
  output logic        mem_write,
  output addr_t       mem_addr,
  output word_t       mem_wdata,
  input  logic        mem_ready,
  input  word_t       mem_rdata,
  output logic        buf_push,
  output logic        buf_pop,
  output word_t       buf_data_in,
  input  word_t       buf_data_out
);

  engine_state_t state;
  chunk_len_t    len;
  chunk_len_t    beats;
  chunk_len_t    burst_len;
  chunk_len_t    len_now;
  addr_t         rd_addr;
  addr_t         wr_addr;
  addr_t         rd_step;
  logic          beat_ok;
  logic          last_beat;

  always_comb
  begin
    case (burst_mode)
      BM_SINGLE: burst_len = 3'd1;
      BM_DUAL:   burst_len = 3'd2;
      BM_QUAD:   burst_len = 3'd4;
      default:   burst_len = chunk_len_t'(MAX_BURST);
    endcase
  end

  // Short tail when fewer words remain than a full burst
  assign len_now = (count < count_t'(burst_len)) ? chunk_len_t'(count) : burst_len;

  assign beat_ok   = mem_req && mem_ready;
  assign last_beat = (beats == len - 3'd1);

  assign rd_step    = src_fixed ? rd_addr : rd_addr + addr_t'(4);
  assign src_next   = rd_addr;
  assign dst_next   = dst_fixed ? wr_addr : wr_addr + addr_t'(4);
  assign count_next = count - count_t'(len);

  assign chunk_start = (state == IDLE) && go;
  assign chunk_done  = (state == WRITE) && beat_ok && last_beat;

  // ================================================
  // Memory master port
  // ================================================
  assign mem_req     = (state == READ) || (state == WRITE);
  assign mem_write   = (state == WRITE);
  assign mem_addr    = mem_write ? wr_addr : rd_addr;
  assign mem_wdata   = buf_data_out;
  assign buf_push    = (state == READ) && beat_ok;
  assign buf_pop     = (state == WRITE) && beat_ok;
  assign buf_data_in = mem_rdata;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state <= IDLE;
      len   <= '0;
      beats <= '0;
    end
    else
    begin
      case (state)
        IDLE:
          if (go)
          begin
            len   <= len_now;
            beats <= '0;
            state <= READ;
          end
        READ:
          if (beat_ok)
          begin
            beats <= beats + 3'd1;
            if (last_beat)
              state <= TURN;
          end
        TURN:
        begin
          beats <= '0;
          state <= WRITE;
        end
        WRITE:
          if (beat_ok)
          begin
            beats <= beats + 3'd1;
            if (last_beat)
              state <= IDLE;
          end
        default: state <= IDLE;
      endcase
    end
  end

  // Beat addresses, stepped on each accepted beat
  always_ff @(posedge clk)
  begin
    if (chunk_start)
    begin
      rd_addr <= src_addr;
      wr_addr <= dst_addr;
    end
    else if (buf_push)
      rd_addr <= rd_step;
    else if (buf_pop)
      wr_addr <= dst_next;
  end

endmodule

`default_nettype wire

// File: dma_burst_buffer.sv
`default_nettype none
`timescale 1ns/1ps

module dma_burst_buffer import dma_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  clear,
  input  logic  push,
  input  logic  pop,
  input  word_t push_data,
  output word_t pop_data,
  output logic  empty,
  output logic  full
);

  localparam int PW = $clog2(MAX_BURST);
  localparam int CW = $clog2(MAX_BURST + 1);

  word_t         mem [MAX_BURST];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] level;

  assign pop_data = mem[rd_ptr];
  assign empty    = (level == '0);
  assign full     = (level == CW'(MAX_BURST));

  always_ff @(posedge clk)
  begin
    if (!rst_n || clear)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + PW'(1);
      if (pop)
        rd_ptr <= rd_ptr + PW'(1);
      case ({push, pop})
        2'b10:   level <= level + CW'(1);
        2'b01:   level <= level - CW'(1);
        default: level <= level;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= push_data;
  end

  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n) !(push && full)
  ) else $error("push into full burst buffer");

  a_no_underflow: assert property (
    @(posedge clk) disable iff (!rst_n) !(pop && empty)
  ) else $error("pop from empty burst buffer");

endmodule

`default_nettype wire

// File: dma_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

module dma_arbiter import dma_pkg::*; #(
  parameter int NUM_CH = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [NUM_CH-1:0] pending,
  input  prio_t [NUM_CH-1:0] prio_list,
  input  logic              arbitrate,
  output logic [NUM_CH-1:0] grant_oh,
  output logic [1:0]        owner
);

  logic [NUM_CH-1:0] pick_oh;
  logic [1:0]        pick_idx;
  prio_t             best_prio;
  logic              found;

  // Strict compare keeps ties on the lower index
  always_comb
  begin
    pick_oh   = '0;
    pick_idx  = '0;
    best_prio = '0;
    found     = 1'b0;
    for (int i = 0; i < NUM_CH; i++)
    begin
      if (pending[i] && (!found || prio_list[i] > best_prio))
      begin
        found      = 1'b1;
        best_prio  = prio_list[i];
        pick_idx   = 2'(i);
        pick_oh    = '0;
        pick_oh[i] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      grant_oh <= '0;
      owner    <= '0;
    end
    else if (arbitrate)
    begin
      grant_oh <= pick_oh;
      owner    <= pick_idx;
    end
  end

  a_grant_onehot: assert property (
    @(posedge clk) disable iff (!rst_n) $onehot0(grant_oh)
  ) else $error("more than one channel granted");

endmodule

`default_nettype wire

// File: dma_channel_regs.sv
`default_nettype none
`timescale 1ns/1ps

module dma_channel_regs import dma_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        wr_en,
  input  logic        rd_en,
  input  logic [3:0]  reg_offset,
  input  word_t       wdata,
  output word_t       rdata,
  input  logic        granted,
  input  logic        chunk_done,
  input  addr_t       src_next,
  input  addr_t       dst_next,
  input  count_t      count_next,
  output addr_t       src_addr,
  output addr_t       dst_addr,
  output count_t      count,
  output burst_mode_t burst_mode,
  output logic        src_fixed,
  output logic        dst_fixed,
  output prio_t       prio,
  output logic        pending,
  output logic        done_intr
);

  logic start;
  logic done;
  logic write_back;

  assign write_back = granted && chunk_done;
  assign pending    = start && (count != '0);
  assign done_intr  = done;

  // ================================================
  // Control word and remaining count
  // ================================================
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      start      <= 1'b0;
      done       <= 1'b0;
      count      <= '0;
      burst_mode <= BM_SINGLE;
      src_fixed  <= 1'b0;
      dst_fixed  <= 1'b0;
      prio       <= '0;
    end
    else
    begin
      if (wr_en && reg_offset == REG_COUNT)
        count <= wdata[15:0];
      if (wr_en && reg_offset == REG_CTRL)
      begin
        start      <= wdata[CTRL_START];
        burst_mode <= wdata[CTRL_MODE_HI:CTRL_MODE_LO];
        src_fixed  <= wdata[CTRL_SRC_FIXED];
        dst_fixed  <= wdata[CTRL_DST_FIXED];
        prio       <= wdata[CTRL_PRIO_HI:CTRL_PRIO_LO];
        // Write one to clear
        if (wdata[CTRL_DONE])
          done <= 1'b0;
      end
      if (write_back)
      begin
        count <= count_next;
        if (count_next == '0)
        begin
          start <= 1'b0;
          done  <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_en && reg_offset == REG_SRC)
      src_addr <= wdata;
    if (wr_en && reg_offset == REG_DST)
      dst_addr <= wdata;
    if (write_back)
    begin
      src_addr <= src_next;
      dst_addr <= dst_next;
    end
  end

  always_comb
  begin
    rdata = '0;
    if (rd_en)
    begin
      case (reg_offset)
        REG_SRC:   rdata = src_addr;
        REG_DST:   rdata = dst_addr;
        REG_COUNT: rdata = word_t'(count);
        REG_CTRL:
        begin
          rdata[CTRL_START]                = start;
          rdata[CTRL_MODE_HI:CTRL_MODE_LO] = burst_mode;
          rdata[CTRL_SRC_FIXED]            = src_fixed;
          rdata[CTRL_DST_FIXED]            = dst_fixed;
          rdata[CTRL_PRIO_HI:CTRL_PRIO_LO] = prio;
          rdata[CTRL_DONE]                 = done;
        end
        default:   rdata = '0;
      endcase
    end
  end

  // Software must not touch a bank while its chunk is retiring
  a_no_wr_on_write_back: assert property (
    @(posedge clk) disable iff (!rst_n) !(wr_en && write_back)
  ) else $error("APB write collided with chunk write-back");

endmodule

`default_nettype wire

// File: dma_pkg.sv
`default_nettype none

package dma_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [15:0] count_t;
  typedef logic [2:0]  prio_t;
  typedef logic [1:0]  burst_mode_t;
  typedef logic [2:0]  chunk_len_t;

  localparam int MAX_BURST = 4;

  // Burst mode codes, code 3 behaves as quad
  localparam burst_mode_t BM_SINGLE = 2'd0;
  localparam burst_mode_t BM_DUAL   = 2'd1;
  localparam burst_mode_t BM_QUAD   = 2'd2;

  // Channel-local byte offsets
  localparam logic [3:0] REG_SRC   = 4'h0;
  localparam logic [3:0] REG_DST   = 4'h4;
  localparam logic [3:0] REG_COUNT = 4'h8;
  localparam logic [3:0] REG_CTRL  = 4'hc;

  // CTRL bit positions
  localparam int CTRL_START     = 0;
  localparam int CTRL_MODE_LO   = 1;
  localparam int CTRL_MODE_HI   = 2;
  localparam int CTRL_SRC_FIXED = 3;
  localparam int CTRL_DST_FIXED = 4;
  localparam int CTRL_PRIO_LO   = 5;
  localparam int CTRL_PRIO_HI   = 7;
  localparam int CTRL_DONE      = 8;

  typedef enum logic [1:0] {
    IDLE,
    READ,
    TURN,
    WRITE
  } engine_state_t;

endpackage

`default_nettype wire
